// ==== source/npc_pkg.sv ====
package npc_pkg;

  localparam int XLEN       = 64;
  localparam int ILEN       = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [ILEN-1:0]       inst_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  localparam xlen_t RESET_PC = 64'h0000_0000_8000_0000;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // lui, operand b straight through
  } alu_op_t;

  typedef enum logic [3:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU,
    BR_JAL,
    BR_JALR
  } br_type_t;

endpackage

// ==== source/npc_fetch.sv ====
`timescale 1ns/1ps

module npc_fetch import npc_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  redirect,
  input  xlen_t redirect_pc,
  output xlen_t pc
);

  // no stalls, so pc moves every cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (redirect) begin
      pc <= redirect_pc;  // taken branch or jump from execute
    end else begin
      pc <= pc + xlen_t'(4);
    end
  end

endmodule

// ==== source/npc_regfile.sv ====
`timescale 1ns/1ps

module npc_regfile import npc_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output xlen_t     rs1_data,
  output xlen_t     rs2_data,
  input  logic      wen,
  input  reg_addr_t waddr,
  input  xlen_t     wdata
);

  xlen_t regs [1:31];  // x0 has no storage

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // write-through so decode sees the value retiring this cycle
  assign rs1_data = (rs1 == '0) ? '0 :
                    (wen && waddr == rs1) ? wdata : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 :
                    (wen && waddr == rs2) ? wdata : regs[rs2];

endmodule

// ==== source/npc_decode.sv ====
`timescale 1ns/1ps

module npc_decode import npc_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  xlen_t     pc,
  input  inst_t     inst,
  input  logic      squash,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  input  xlen_t     rs1_data,
  input  xlen_t     rs2_data,
  output logic      ex_valid,
  output xlen_t     ex_pc,
  output reg_addr_t ex_rd,
  output reg_addr_t ex_rs1,
  output reg_addr_t ex_rs2,
  output xlen_t     ex_rs1_data,
  output xlen_t     ex_rs2_data,
  output xlen_t     ex_imm,
  output alu_op_t   ex_alu_op,
  output br_type_t  ex_br_type,
  output logic      ex_use_imm,
  output logic      ex_use_pc,
  output logic      ex_wen
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i, imm_u, imm_b, imm_j;

  alu_op_t  alu_op;
  br_type_t br_type;
  logic     use_imm, use_pc, wen;
  xlen_t    imm;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    // default covers unsupported encodings, retires with no write
    alu_op  = ALU_ADD;
    br_type = BR_NONE;
    use_imm = 1'b0;
    use_pc  = 1'b0;
    wen     = 1'b0;
    imm     = imm_i;
    case (opcode)
      OPC_LUI: begin
        alu_op  = ALU_PASS_B;
        use_imm = 1'b1;
        imm     = imm_u;
        wen     = 1'b1;
      end
      OPC_AUIPC: begin
        use_pc  = 1'b1;
        use_imm = 1'b1;
        imm     = imm_u;
        wen     = 1'b1;
      end
      OPC_JAL: begin
        br_type = BR_JAL;  // alu forms the target, link is pc+4
        use_pc  = 1'b1;
        use_imm = 1'b1;
        imm     = imm_j;
        wen     = 1'b1;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          br_type = BR_JALR;
          use_imm = 1'b1;
          wen     = 1'b1;
        end
      end
      OPC_BRANCH: begin
        use_pc  = 1'b1;
        use_imm = 1'b1;
        imm     = imm_b;
        case (funct3)
          3'b000:  br_type = BR_EQ;
          3'b001:  br_type = BR_NE;
          3'b100:  br_type = BR_LT;
          3'b101:  br_type = BR_GE;
          3'b110:  br_type = BR_LTU;
          3'b111:  br_type = BR_GEU;
          default: br_type = BR_NONE;
        endcase
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        wen     = 1'b1;
        case (funct3)
          3'b000: alu_op = ALU_ADD;
          3'b010: alu_op = ALU_SLT;
          3'b011: alu_op = ALU_SLTU;
          3'b100: alu_op = ALU_XOR;
          3'b110: alu_op = ALU_OR;
          3'b111: alu_op = ALU_AND;
          3'b001: begin
            alu_op = ALU_SLL;
            wen    = (inst[31:26] == 6'b0);
          end
          default: begin  // srli / srai, shamt in imm[5:0]
            alu_op = inst[30] ? ALU_SRA : ALU_SRL;
            wen    = (inst[31] == 1'b0) && (inst[29:26] == 4'b0);
          end
        endcase
      end
      OPC_OP: begin
        if (funct7 == 7'b0000000) begin
          wen = 1'b1;
          case (funct3)
            3'b000:  alu_op = ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
          endcase
        end else if (funct7 == 7'b0100000) begin
          // only sub and sra live here
          wen    = (funct3 == 3'b000) || (funct3 == 3'b101);
          alu_op = (funct3 == 3'b101) ? ALU_SRA : ALU_SUB;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst || squash) begin
      ex_valid <= 1'b0;  // kills the instruction behind a taken branch
    end else begin
      ex_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    ex_pc       <= pc;
    ex_rd       <= inst[11:7];
    ex_rs1      <= rs1;
    ex_rs2      <= rs2;
    ex_rs1_data <= rs1_data;
    ex_rs2_data <= rs2_data;
    ex_imm      <= imm;
    ex_alu_op   <= alu_op;
    ex_br_type  <= br_type;
    ex_use_imm  <= use_imm;
    ex_use_pc   <= use_pc;
    ex_wen      <= wen;
  end

endmodule

// ==== source/npc_execute.sv ====
`timescale 1ns/1ps

module npc_execute import npc_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      ex_valid,
  input  xlen_t     ex_pc,
  input  reg_addr_t ex_rd,
  input  reg_addr_t ex_rs1,
  input  reg_addr_t ex_rs2,
  input  xlen_t     ex_rs1_data,
  input  xlen_t     ex_rs2_data,
  input  xlen_t     ex_imm,
  input  alu_op_t   ex_alu_op,
  input  br_type_t  ex_br_type,
  input  logic      ex_use_imm,
  input  logic      ex_use_pc,
  input  logic      ex_wen,
  output logic      redirect,
  output xlen_t     redirect_pc,
  output logic      wb_valid,
  output xlen_t     wb_pc,
  output reg_addr_t wb_rd,
  output logic      wb_wen,
  output xlen_t     wb_data
);

  logic  fwd_ok;
  xlen_t src1, src2;
  xlen_t op_a, op_b;
  xlen_t alu_out;
  xlen_t link;
  logic  taken;
  logic  is_jump;

  // older instruction sitting in the result register
  assign fwd_ok = wb_valid && wb_wen && (wb_rd != '0);

  assign src1 = (fwd_ok && wb_rd == ex_rs1) ? wb_data : ex_rs1_data;
  assign src2 = (fwd_ok && wb_rd == ex_rs2) ? wb_data : ex_rs2_data;

  assign op_a = ex_use_pc  ? ex_pc  : src1;
  assign op_b = ex_use_imm ? ex_imm : src2;

  always_comb begin
    case (ex_alu_op)
      ALU_ADD:    alu_out = op_a + op_b;
      ALU_SUB:    alu_out = op_a - op_b;
      ALU_SLL:    alu_out = op_a << op_b[5:0];
      ALU_SLT:    alu_out = {63'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_out = {63'b0, op_a < op_b};
      ALU_XOR:    alu_out = op_a ^ op_b;
      ALU_SRL:    alu_out = op_a >> op_b[5:0];
      ALU_SRA:    alu_out = xlen_t'($signed(op_a) >>> op_b[5:0]);
      ALU_OR:     alu_out = op_a | op_b;
      ALU_AND:    alu_out = op_a & op_b;
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = op_a + op_b;
    endcase
  end

  // branch compare always on the register operands
  always_comb begin
    case (ex_br_type)
      BR_EQ:   taken = (src1 == src2);
      BR_NE:   taken = (src1 != src2);
      BR_LT:   taken = $signed(src1) < $signed(src2);
      BR_GE:   taken = $signed(src1) >= $signed(src2);
      BR_LTU:  taken = src1 < src2;
      BR_GEU:  taken = src1 >= src2;
      BR_JAL,
      BR_JALR: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign is_jump = (ex_br_type == BR_JAL) || (ex_br_type == BR_JALR);
  assign link    = ex_pc + xlen_t'(4);

  assign redirect    = ex_valid && taken;
  assign redirect_pc = (ex_br_type == BR_JALR) ? {alu_out[63:1], 1'b0} : alu_out;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    wb_pc   <= ex_pc;
    wb_rd   <= ex_rd;
    wb_wen  <= ex_wen;
    wb_data <= is_jump ? link : alu_out;  // jumps write the link
  end

endmodule

// ==== source/npc_result.sv ====
`timescale 1ns/1ps

module npc_result import npc_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      wb_valid,
  input  xlen_t     wb_pc,
  input  reg_addr_t wb_rd,
  input  logic      wb_wen,
  input  xlen_t     wb_data,
  output logic      rf_wen,
  output reg_addr_t rf_waddr,
  output xlen_t     rf_wdata,
  output logic      retire_valid,
  output xlen_t     retire_pc,
  output reg_addr_t retire_rd,
  output logic      retire_wen,
  output xlen_t     retire_data,
  output xlen_t     retire_count
);

  assign rf_wen   = wb_valid && wb_wen;
  assign rf_waddr = wb_rd;
  assign rf_wdata = wb_data;

  assign retire_valid = wb_valid;
  assign retire_pc    = wb_pc;
  assign retire_rd    = wb_rd;
  assign retire_wen   = rf_wen && (wb_rd != '0);  // x0 writes have no effect
  assign retire_data  = wb_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_count <= '0;
    end else if (wb_valid) begin
      retire_count <= retire_count + xlen_t'(1);
    end
  end

endmodule

// ==== source/npc_core.sv ====
`timescale 1ns/1ps

module npc_core import npc_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  output xlen_t     pc,
  input  inst_t     inst,
  output xlen_t     wb_pc,         // pc of the retiring instruction
  output logic      retire_valid,
  output reg_addr_t retire_rd,
  output logic      retire_wen,
  output xlen_t     retire_data,
  output xlen_t     retire_count
);

  logic      redirect;
  xlen_t     redirect_pc;

  reg_addr_t rs1, rs2;
  xlen_t     rs1_data, rs2_data;
  logic      rf_wen;
  reg_addr_t rf_waddr;
  xlen_t     rf_wdata;

  // decode to execute
  logic      ex_valid;
  xlen_t     ex_pc;
  reg_addr_t ex_rd, ex_rs1, ex_rs2;
  xlen_t     ex_rs1_data, ex_rs2_data, ex_imm;
  alu_op_t   ex_alu_op;
  br_type_t  ex_br_type;
  logic      ex_use_imm, ex_use_pc, ex_wen;

  // execute to result
  logic      res_valid;
  xlen_t     res_pc;
  reg_addr_t res_rd;
  logic      res_wen;
  xlen_t     res_data;

  npc_fetch u_fetch (
    .clk         (clk),
    .rst         (rst),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .pc          (pc)
  );

  npc_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wen      (rf_wen),
    .waddr    (rf_waddr),
    .wdata    (rf_wdata)
  );

  npc_decode u_decode (
    .clk         (clk),
    .rst         (rst),
    .pc          (pc),
    .inst        (inst),
    .squash      (redirect),  // drop the wrong-path fetch
    .rs1         (rs1),
    .rs2         (rs2),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .ex_valid    (ex_valid),
    .ex_pc       (ex_pc),
    .ex_rd       (ex_rd),
    .ex_rs1      (ex_rs1),
    .ex_rs2      (ex_rs2),
    .ex_rs1_data (ex_rs1_data),
    .ex_rs2_data (ex_rs2_data),
    .ex_imm      (ex_imm),
    .ex_alu_op   (ex_alu_op),
    .ex_br_type  (ex_br_type),
    .ex_use_imm  (ex_use_imm),
    .ex_use_pc   (ex_use_pc),
    .ex_wen      (ex_wen)
  );

  npc_execute u_execute (
    .clk         (clk),
    .rst         (rst),
    .ex_valid    (ex_valid),
    .ex_pc       (ex_pc),
    .ex_rd       (ex_rd),
    .ex_rs1      (ex_rs1),
    .ex_rs2      (ex_rs2),
    .ex_rs1_data (ex_rs1_data),
    .ex_rs2_data (ex_rs2_data),
    .ex_imm      (ex_imm),
    .ex_alu_op   (ex_alu_op),
    .ex_br_type  (ex_br_type),
    .ex_use_imm  (ex_use_imm),
    .ex_use_pc   (ex_use_pc),
    .ex_wen      (ex_wen),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .wb_valid    (res_valid),
    .wb_pc       (res_pc),
    .wb_rd       (res_rd),
    .wb_wen      (res_wen),
    .wb_data     (res_data)
  );

  npc_result u_result (
    .clk          (clk),
    .rst          (rst),
    .wb_valid     (res_valid),
    .wb_pc        (res_pc),
    .wb_rd        (res_rd),
    .wb_wen       (res_wen),
    .wb_data      (res_data),
    .rf_wen       (rf_wen),
    .rf_waddr     (rf_waddr),
    .rf_wdata     (rf_wdata),
    .retire_valid (retire_valid),
    .retire_pc    (wb_pc),
    .retire_rd    (retire_rd),
    .retire_wen   (retire_wen),
    .retire_data  (retire_data),
    .retire_count (retire_count)
  );

endmodule

// ==== sim/npc_tests.svh ====
// squashed slot after a taken branch or jump, retires only when not taken
localparam inst_t SHADOW_INST = {12'h05a, 5'd0, 3'd0, 5'd30, 7'b0010011};

function automatic inst_t enc_r(int f7, int rs2, int rs1, int f3, int rd, logic [6:0] opc);
  return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), opc};
endfunction

function automatic inst_t enc_i(logic [11:0] imm, int rs1, int f3, int rd, logic [6:0] opc);
  return {imm, 5'(rs1), 3'(f3), 5'(rd), opc};
endfunction

function automatic inst_t enc_u(logic [19:0] imm, int rd, logic [6:0] opc);
  return {imm, 5'(rd), opc};
endfunction

function automatic inst_t enc_b(logic [12:0] off, int rs2, int rs1, int f3);
  return {off[12], off[10:5], 5'(rs2), 5'(rs1), 3'(f3), off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic inst_t enc_j(logic [20:0] off, int rd);
  return {off[20], off[10:1], off[11], off[19:12], 5'(rd), OPC_JAL};
endfunction

function automatic xlen_t sext12(logic [11:0] v);
  return {{52{v[11]}}, v};
endfunction

function automatic xlen_t upper_imm(logic [19:0] imm);
  return {{32{imm[19]}}, imm, 12'h000};
endfunction

// two's complement order: differing signs decide on their own
function automatic logic signed_less(xlen_t a, xlen_t b);
  return (a[63] != b[63]) ? a[63] : (a < b);
endfunction

function automatic xlen_t op_rule(logic [2:0] f3, logic alt, xlen_t a, xlen_t b);
  logic [5:0] sh;
  xlen_t      hi_fill;
  sh = b[5:0];
  hi_fill = ~(~xlen_t'(0) >> sh);  // top sh bits set
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << sh;
    3'b010:  return {63'b0, signed_less(a, b)};
    3'b011:  return {63'b0, a < b};
    3'b100:  return a ^ b;
    3'b101:  return (alt && a[63]) ? ((a >> sh) | hi_fill) : (a >> sh);
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_rule(logic [2:0] f3, xlen_t a, xlen_t b);
  case (f3)
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return signed_less(a, b);
    3'b101:  return !signed_less(a, b);
    3'b110:  return a < b;
    default: return !(a < b);
  endcase
endfunction

task automatic do_op(int f3, int alt, int rd, int rs1, int rs2);
  put_exp(enc_r(alt != 0 ? 32 : 0, rs2, rs1, f3, rd, OPC_OP), rd, 1'b1,
          op_rule(3'(f3), alt != 0, rf_model[rs1], rf_model[rs2]));
endtask

task automatic do_imm(int f3, int alt, int rd, int rs1, int imm);
  logic [11:0] imm12;
  imm12 = 12'(imm);
  if (f3 == 1 || f3 == 5) begin
    imm12 = {1'b0, alt != 0, 4'b0000, imm12[5:0]};  // shamt with the sra bit
  end
  put_exp(enc_i(imm12, rs1, f3, rd, OPC_OP_IMM), rd, 1'b1,
          op_rule(3'(f3), alt != 0, rf_model[rs1], sext12(imm12)));
endtask

task automatic do_lui(int rd, logic [19:0] imm);
  put_exp(enc_u(imm, rd, OPC_LUI), rd, 1'b1, upper_imm(imm));
endtask

task automatic do_auipc(int rd, logic [19:0] imm);
  put_exp(enc_u(imm, rd, OPC_AUIPC), rd, 1'b1, cursor + upper_imm(imm));
endtask

task automatic load_const(int rd, logic [31:0] v);
  logic [31:0] adj;
  adj = v + 32'h800;  // addi adds a signed low part
  do_lui(rd, adj[31:12]);
  do_imm(0, 0, rd, rd, int'(v[11:0]));
endtask

task automatic do_branch(int f3, int rs1, int rs2);
  logic taken;
  taken = branch_rule(3'(f3), rf_model[rs1], rf_model[rs2]);
  put_exp(enc_b(13'd8, rs2, rs1, f3), 0, 1'b0, '0);
  if (taken) begin
    put(SHADOW_INST);
  end else begin
    put_exp(SHADOW_INST, 30, 1'b1, 64'h5a);
  end
endtask

task automatic do_jal(int rd, int off);
  xlen_t target;
  target = cursor + xlen_t'(off);
  put_exp(enc_j(21'(off), rd), rd, 1'b1, cursor + xlen_t'(4));
  put(SHADOW_INST);
  cursor = target;
endtask

task automatic do_jalr(int rd, int rs1, int imm);
  xlen_t target;
  target = rf_model[rs1] + sext12(12'(imm));
  target[0] = 1'b0;
  put_exp(enc_i(12'(imm), rs1, 0, rd, OPC_JALR), rd, 1'b1, cursor + xlen_t'(4));
  put(SHADOW_INST);
  cursor = target;
endtask

task automatic test_reset();
  new_program();
  do_imm(0, 0, 1, 0, 5);
  do_imm(0, 0, 2, 1, -3);
  run_program(BUDGET_RESET);
  // rst falls inside the first fetch cycle, retire two falling edges later
  if (first_retire != 2) begin
    value_errors++;
    $display("Mismatch first_retire_cycle: got %h, expected %h", first_retire, 2);
  end
endtask

task automatic test_alu();
  new_program();
  for (int i = 1; i <= 4; i++) begin
    load_const(i, $urandom());
  end
  do_op(0, 0, 5, 1, 2);  // back to back from here on
  do_op(0, 1, 6, 5, 3);
  do_imm(1, 0, 7, 6, 33);
  do_op(1, 0, 8, 7, 4);
  do_op(2, 0, 9, 8, 6);
  do_op(3, 0, 10, 8, 6);
  do_op(4, 0, 11, 7, 8);
  do_op(5, 0, 12, 11, 1);
  do_op(5, 1, 13, 11, 2);
  do_op(6, 0, 14, 13, 12);
  do_op(7, 0, 15, 14, 11);
  do_imm(0, 0, 16, 15, -7);
  do_imm(2, 0, 17, 16, -2048);
  do_imm(3, 0, 18, 16, -1);
  do_imm(4, 0, 19, 16, 'h5a5);
  do_imm(6, 0, 20, 19, 'h0f0);
  do_imm(7, 0, 21, 20, 'h8f3);
  do_imm(5, 0, 22, 21, 7);
  do_imm(5, 1, 23, 13, 45);
  do_op(0, 0, 24, 23, 22);
  run_program(BUDGET_ALU);
endtask

task automatic test_upper();
  logic [19:0] r;
  new_program();
  r = 20'($urandom());
  do_lui(1, 20'h12345);
  do_lui(2, 20'h80000);  // sign bit of the 32-bit value
  do_lui(3, r);
  do_auipc(4, 20'h00001);
  do_auipc(5, 20'hfffff);
  do_auipc(6, r);
  do_op(0, 0, 7, 4, 5);
  run_program(BUDGET_UPPER);
endtask

task automatic test_branches();
  int f3s [6] = '{0, 1, 4, 5, 6, 7};
  int pa [3] = '{1, 1, 3};
  int pb [3] = '{2, 3, 1};
  new_program();
  load_const(1, 32'h0000_1234);
  load_const(2, 32'h0000_1234);
  load_const(3, $urandom() | 32'h8000_0000);  // negative, so signed and unsigned differ
  for (int k = 0; k < 6; k++) begin
    for (int p = 0; p < 3; p++) begin
      do_branch(f3s[k], pa[p], pb[p]);
    end
  end
  do_jal(1, 12);
  do_op(0, 0, 9, 1, 0);
  do_auipc(5, 20'h00000);
  do_jalr(6, 5, 17);  // odd target, bit 0 dropped
  do_op(0, 0, 10, 6, 0);
  run_program(BUDGET_BRANCH);
endtask

task automatic test_x0_unsupported();
  new_program();
  load_const(7, $urandom());
  do_imm(0, 0, 0, 7, 100);
  do_op(0, 0, 0, 7, 7);
  do_op(0, 0, 8, 0, 7);
  do_imm(0, 0, 9, 0, 0);
  put_exp(enc_i(12'h010, 1, 3, 7, 7'b0000011), 7, 1'b0, '0);  // ld
  put_exp(enc_r(1, 7, 7, 0, 7, OPC_OP), 7, 1'b0, '0);         // mul
  do_imm(0, 0, 10, 7, 0);
  run_program(BUDGET_X0);
endtask

// ==== sim/npc_tb.sv ====
`timescale 1ns/1ps

module npc_tb import npc_pkg::*; ();

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 16;
  localparam int IMEM_WORDS    = 256;  // word index is pc offset bits [9:2]
  localparam int BUDGET_RESET  = 20;
  localparam int BUDGET_ALU    = 80;
  localparam int BUDGET_UPPER  = 40;
  localparam int BUDGET_BRANCH = 100;
  localparam int BUDGET_X0     = 40;
  localparam int RUN_CYCLES    = 5 * (RESET_CYCLES + 1) + BUDGET_RESET + BUDGET_ALU +
                                 BUDGET_UPPER + BUDGET_BRANCH + BUDGET_X0;

  logic      clk;
  logic      rst;
  inst_t     inst;
  xlen_t     pc;
  xlen_t     retire_pc;
  logic      retire_valid;
  reg_addr_t retire_rd;
  logic      retire_wen;
  xlen_t     retire_data;
  xlen_t     retire_count;

  inst_t imem [0:IMEM_WORDS-1];
  xlen_t rf_model [0:31];  // architectural registers after the placed program
  xlen_t cursor;           // pc of the next placed instruction

  // expected retire stream in program order
  xlen_t     exp_pc [$];
  reg_addr_t exp_rd [$];
  logic      exp_wen [$];
  xlen_t     exp_data [$];

  int          value_errors;
  int          other_errors;
  int          first_retire;
  int unsigned seed_draw;

  npc_core u_dut (
    .clk          (clk),
    .rst          (rst),
    .pc           (pc),
    .inst         (inst),
    .wb_pc        (retire_pc),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_wen   (retire_wen),
    .retire_data  (retire_data),
    .retire_count (retire_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [7:0] word_index(xlen_t addr);
    xlen_t off;
    off = addr - RESET_PC;
    return off[9:2];
  endfunction

  function automatic inst_t fetch_word(xlen_t addr);
    xlen_t off;
    off = addr - RESET_PC;
    if ($isunknown(addr) || off >= xlen_t'(IMEM_WORDS * 4)) begin
      return {12'h000, 5'd0, 3'd0, 5'd0, OPC_OP_IMM};  // plain nop outside the array
    end
    return imem[word_index(addr)];
  endfunction

  // memory answers the current pc on each falling edge
  always @(negedge clk) begin
    inst <= fetch_word(pc);
  end

  task automatic check_word(input string name, input xlen_t got, input xlen_t want);
    if (got !== want) begin
      value_errors++;
      $display("Mismatch %s at %0t: got %h, expected %h", name, $time, got, want);
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t want);
    if (got !== want) begin
      value_errors++;
      $display("Mismatch %s at %0t: got %h, expected %h", name, $time, got, want);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      value_errors++;
      $display("Mismatch %s at %0t: got %h, expected %h", name, $time, got, want);
    end
  endtask

  task automatic new_program();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = {4'b0, 8'(i), 5'd0, 3'd0, 5'd0, OPC_OP_IMM};  // x0 nop tagged with its index
    end
    for (int r = 0; r < 32; r++) begin
      rf_model[r] = '0;
    end
    exp_pc.delete();
    exp_rd.delete();
    exp_wen.delete();
    exp_data.delete();
    cursor = RESET_PC;
  endtask

  // instruction that is never expected to retire (wrong path)
  task automatic put(input inst_t word);
    imem[word_index(cursor)] = word;
    cursor = cursor + xlen_t'(4);
  endtask

  task automatic put_exp(input inst_t word, input int rd, input logic writes, input xlen_t data);
    logic wen;
    wen = writes && (rd != 0);
    exp_pc.push_back(cursor);
    exp_rd.push_back(reg_addr_t'(rd));
    exp_wen.push_back(wen);
    exp_data.push_back(data);
    if (wen) begin
      rf_model[rd] = data;
    end
    put(word);
  endtask

  task automatic pulse_reset();
    @(negedge clk);
    rst = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    check_word("pc", pc, RESET_PC);
    check_bit("retire_valid", retire_valid, 1'b0);
    check_word("retire_count", retire_count, '0);
    rst = 1'b0;
  endtask

  task automatic run_program(input int budget);
    int n;
    int cycles;
    n = 0;
    cycles = 0;
    first_retire = -1;
    pulse_reset();
    while (n < exp_pc.size() && cycles < budget) begin
      @(negedge clk);
      cycles++;
      if (retire_valid) begin
        if (n == 0) begin
          first_retire = cycles;
        end
        check_word($sformatf("retire_pc[%0d]", n), retire_pc, exp_pc[n]);
        check_bit($sformatf("retire_wen[%0d]", n), retire_wen, exp_wen[n]);
        check_word($sformatf("retire_count[%0d]", n), retire_count, xlen_t'(n));
        if (exp_wen[n]) begin
          check_reg($sformatf("retire_rd[%0d]", n), retire_rd, exp_rd[n]);
          check_word($sformatf("retire_data[%0d]", n), retire_data, exp_data[n]);
        end
        n++;
      end
    end
    if (n < exp_pc.size()) begin
      other_errors++;
      $display("retire stream ended early: %0d of %0d instructions retired in %0d cycles",
               n, exp_pc.size(), cycles);
    end
  endtask

`include "npc_tests.svh"

  initial begin
    rst = 1'b1;
    inst = {12'h000, 5'd0, 3'd0, 5'd0, OPC_OP_IMM};
    value_errors = 0;
    other_errors = 0;
    first_retire = -1;
    seed_draw = $urandom(32'h37441e17);
    test_reset();
    test_alu();
    test_upper();
    test_branches();
    test_x0_unsupported();
    $display("errors: %0d mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(RUN_CYCLES * 2 * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+sim
source/npc_pkg.sv
source/npc_fetch.sv
source/npc_regfile.sv
source/npc_decode.sv
source/npc_execute.sv
source/npc_result.sv
source/npc_core.sv
sim/npc_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the npc_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module npc_tb -f compile.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/Vnpc_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1
